/* hdl/cce_pkg.sv */
// CCE register subsystem package
// Widths, opcode and state encodings, and the packed structs shared by the
// decoder, the LCE request buffer, the ALU and the register file

package cce_pkg;

  localparam int num_gpr_lp       = 4;
  localparam int gpr_width_lp     = 16;
  localparam int gpr_sel_width_lp = $clog2(num_gpr_lp);
  localparam int imm_width_lp     = 8;
  localparam int paddr_width_lp   = 12;
  localparam int lce_id_width_lp  = 2;
  localparam int num_flags_lp     = 4;

  // Lowest uncacheable physical address
  localparam logic [paddr_width_lp-1:0] uncached_base_lp = 12'h800;

  // Unlisted codes decode as nop
  typedef enum logic [3:0] {
    e_op_nop     = 4'd0,
    e_op_movi    = 4'd1,
    e_op_add     = 4'd2,
    e_op_sub     = 4'd3,
    e_op_mov     = 4'd4,
    e_op_poph    = 4'd5,
    e_op_clm     = 4'd6,
    e_op_ldflags = 4'd7,
    e_op_setcoh  = 4'd8
  } cce_opcode_e;

  typedef enum logic [1:0] {
    e_coh_i = 2'd0,
    e_coh_s = 2'd1,
    e_coh_e = 2'd2,
    e_coh_m = 2'd3
  } coh_state_e;

  typedef enum logic [1:0] {
    e_req_rd    = 2'd0,
    e_req_wr    = 2'd1,
    e_req_uc_rd = 2'd2,
    e_req_uc_wr = 2'd3
  } lce_req_type_e;

  // Bit positions inside the MSHR flag vector
  typedef enum logic [1:0] {
    e_flag_rqf  = 2'd0,
    e_flag_ucf  = 2'd1,
    e_flag_nerf = 2'd2,
    e_flag_rcf  = 2'd3
  } mshr_flag_e;

  // 16-bit microcode word
  typedef struct packed {
    cce_opcode_e                 op;
    logic [gpr_sel_width_lp-1:0] dst;
    logic [gpr_sel_width_lp-1:0] src_a;
    logic [imm_width_lp-1:0]     imm;
  } cce_inst_s;

  typedef struct packed {
    lce_req_type_e              msg_type;
    logic [lce_id_width_lp-1:0] src_id;
    logic [paddr_width_lp-1:0]  paddr;
    logic [1:0]                 size;
    logic                       non_excl;
  } lce_req_hdr_s;

  typedef struct packed {
    logic [lce_id_width_lp-1:0] lce_id;
    logic [paddr_width_lp-1:0]  paddr;
    logic [1:0]                 msg_size;
    coh_state_e                 next_coh_state;
    logic [num_flags_lp-1:0]    flags;
  } mshr_s;

  typedef struct packed {
    cce_opcode_e                 op;
    logic [gpr_sel_width_lp-1:0] dst;
    logic [gpr_sel_width_lp-1:0] src_a;
    logic [gpr_sel_width_lp-1:0] src_b;
    logic [imm_width_lp-1:0]     imm;
    logic [num_gpr_lp-1:0]       gpr_w_v;
    logic                        mshr_clear;
    logic                        poph;
    logic                        lce_w_v;
    logic                        addr_w_v;
    logic                        msg_size_w_v;
    logic [num_flags_lp-1:0]     flag_w_v;
    logic                        coh_state_w_v;
  } decoded_inst_s;

endpackage

/* hdl/cce_inst_decode.sv */
// CCE microcode instruction decoder
// Turns a microcode word into GPR and per-field MSHR write enables.
// A header pop stalls until the request buffer holds a header.

`timescale 1ns/100ps

module cce_inst_decode (
  input  cce_pkg::cce_inst_s     instr_i,
  input  logic                   instr_v_i,
  input  logic                   hdr_v_i,
  output cce_pkg::decoded_inst_s decoded_o,
  output logic                   stall_o,
  output logic                   pop_o
);

  import cce_pkg::*;

  logic is_poph;

  assign is_poph = instr_v_i && (instr_i.op == e_op_poph);

  // Pop waits for a buffered header, then dequeues it on the executing edge
  assign stall_o = is_poph && !hdr_v_i;
  assign pop_o   = is_poph && hdr_v_i;

  always_comb begin
    decoded_o       = '0;
    decoded_o.op    = instr_i.op;
    decoded_o.dst   = instr_i.dst;
    decoded_o.src_a = instr_i.src_a;
    // Second ALU operand is selected by the low immediate bits
    decoded_o.src_b = instr_i.imm[gpr_sel_width_lp-1:0];
    decoded_o.imm   = instr_i.imm;

    if (instr_v_i) begin
      case (instr_i.op)
        e_op_movi, e_op_add, e_op_sub, e_op_mov: begin
          decoded_o.gpr_w_v[instr_i.dst] = 1'b1;
        end
        e_op_poph: begin
          decoded_o.poph         = 1'b1;
          decoded_o.lce_w_v      = 1'b1;
          decoded_o.addr_w_v     = 1'b1;
          decoded_o.msg_size_w_v = 1'b1;
          decoded_o.flag_w_v     = '1;
        end
        e_op_clm: begin
          decoded_o.mshr_clear = 1'b1;
        end
        e_op_ldflags: begin
          decoded_o.flag_w_v = '1;
        end
        e_op_setcoh: begin
          decoded_o.coh_state_w_v = 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

/* hdl/cce_lce_req_buffer.sv */
// One-entry LCE request header buffer
// Captures a header through a four-phase req/ack handshake and holds it
// until the decoder pops it. While full, the next ack is held off.

`timescale 1ns/100ps

module cce_lce_req_buffer (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  cce_pkg::lce_req_hdr_s lce_req_i,
  input  logic                  lce_req_req_i,
  input  logic                  pop_i,
  output logic                  lce_req_ack_o,
  output cce_pkg::lce_req_hdr_s hdr_o,
  output logic                  hdr_v_o
);

  import cce_pkg::*;

  typedef enum logic {
    e_idle,
    e_acked
  } ack_state_e;

  ack_state_e   state_r;
  lce_req_hdr_s hdr_r;
  logic         full_r;
  logic         capture;

  // Accept only with ack low and the slot empty
  assign capture = lce_req_req_i && !full_r && (state_r == e_idle);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
      full_r  <= 1'b0;
    end else begin
      case (state_r)
        e_idle: begin
          if (capture) begin
            state_r <= e_acked;
          end
        end
        e_acked: begin
          // Release ack once the requester has dropped req
          if (!lce_req_req_i) begin
            state_r <= e_idle;
          end
        end
        default: begin
          state_r <= e_idle;
        end
      endcase

      if (capture) begin
        full_r <= 1'b1;
      end else if (pop_i) begin
        full_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      hdr_r <= lce_req_i;
    end
  end

  assign lce_req_ack_o = (state_r == e_acked);
  assign hdr_o         = hdr_r;
  assign hdr_v_o       = full_r;

  // The decoder only dequeues a header that is actually held
  pop_needs_header_a: assert property (
    @(posedge clk_i) disable iff (reset_i) pop_i |-> hdr_v_o
  ) else $error("cce_lce_req_buffer: pop with empty buffer");

endmodule

/* hdl/cce_alu.sv */
// CCE microcode ALU
// Produces the GPR write value for movi, add, sub and mov

`timescale 1ns/100ps

module cce_alu (
  input  cce_pkg::decoded_inst_s                                    decoded_i,
  input  logic [cce_pkg::num_gpr_lp-1:0][cce_pkg::gpr_width_lp-1:0] gpr_i,
  output logic [cce_pkg::gpr_width_lp-1:0]                          alu_res_o
);

  import cce_pkg::*;

  logic [gpr_width_lp-1:0] src_a;
  logic [gpr_width_lp-1:0] src_b;

  assign src_a = gpr_i[decoded_i.src_a];
  assign src_b = gpr_i[decoded_i.src_b];

  // Add and sub wrap modulo 2^16
  always_comb begin
    case (decoded_i.op)
      e_op_add:  alu_res_o = src_a + src_b;
      e_op_sub:  alu_res_o = src_a - src_b;
      e_op_movi: alu_res_o = {{(gpr_width_lp-imm_width_lp){1'b0}}, decoded_i.imm};
      default:   alu_res_o = src_a;
    endcase
  end

endmodule

/* hdl/cce_reg.sv */
// CCE register file
// Holds the GPRs, the MSHR with its flags and the default coherence state.
// MSHR fields are written under their own enables, from the popped LCE
// request header or from source A. Includes the PMA cacheability check.

`timescale 1ns/100ps

module cce_reg (
  input  logic                                                      clk_i,
  input  logic                                                      reset_i,
  input  cce_pkg::decoded_inst_s                                    decoded_inst_i,
  input  logic                                                      stall_i,
  input  logic [cce_pkg::gpr_width_lp-1:0]                          alu_res_i,
  input  cce_pkg::lce_req_hdr_s                                     lce_req_hdr_i,
  output logic [cce_pkg::num_gpr_lp-1:0][cce_pkg::gpr_width_lp-1:0] gpr_o,
  output cce_pkg::mshr_s                                            mshr_o,
  output cce_pkg::coh_state_e                                       coh_state_o
);

  import cce_pkg::*;

  logic [num_gpr_lp-1:0][gpr_width_lp-1:0] gpr_r;
  logic [gpr_width_lp-1:0]                 src_a;
  logic [num_gpr_lp-1:0]                   gpr_w_mask;
  mshr_s                                   mshr_r;
  mshr_s                                   mshr_n;
  coh_state_e                              coh_state_r;
  coh_state_e                              coh_state_n;
  logic                                    req_rqf;
  logic                                    req_ucf;
  logic                                    req_cacheable;
  logic                                    req_cached_type;

  assign src_a      = gpr_r[decoded_inst_i.src_a];
  assign gpr_w_mask = stall_i ? '0 : decoded_inst_i.gpr_w_v;

  // PMA check, everything from the uncached base upward bypasses the cache
  assign req_cacheable = (lce_req_hdr_i.paddr < uncached_base_lp);

  assign req_rqf = (lce_req_hdr_i.msg_type == e_req_wr)
                   || (lce_req_hdr_i.msg_type == e_req_uc_wr);
  assign req_ucf = (lce_req_hdr_i.msg_type == e_req_uc_rd)
                   || (lce_req_hdr_i.msg_type == e_req_uc_wr);
  assign req_cached_type = (lce_req_hdr_i.msg_type == e_req_rd)
                           || (lce_req_hdr_i.msg_type == e_req_wr);

  assign coh_state_n = coh_state_e'(src_a[1:0]);

  always_comb begin
    mshr_n = mshr_r;
    if (decoded_inst_i.mshr_clear) begin
      // Cleared MSHR starts from the default coherence state
      mshr_n                = '0;
      mshr_n.next_coh_state = coh_state_r;
    end else if (decoded_inst_i.poph) begin
      mshr_n.lce_id             = lce_req_hdr_i.src_id;
      mshr_n.paddr              = lce_req_hdr_i.paddr;
      mshr_n.msg_size           = lce_req_hdr_i.size;
      mshr_n.flags[e_flag_rqf]  = req_rqf;
      mshr_n.flags[e_flag_ucf]  = req_ucf;
      mshr_n.flags[e_flag_nerf] = lce_req_hdr_i.non_excl;
      mshr_n.flags[e_flag_rcf]  = req_cacheable;
    end else begin
      mshr_n.flags = src_a[num_flags_lp-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpr_r       <= '0;
      mshr_r      <= '0;
      coh_state_r <= e_coh_i;
    end else begin
      for (int i = 0; i < num_gpr_lp; i++) begin
        if (gpr_w_mask[i]) begin
          gpr_r[i] <= alu_res_i;
        end
      end

      if (!stall_i && decoded_inst_i.coh_state_w_v) begin
        coh_state_r <= coh_state_n;
      end

      // Clear overrides the per-field writes
      if (!stall_i && decoded_inst_i.mshr_clear) begin
        mshr_r <= mshr_n;
      end else if (!stall_i) begin
        if (decoded_inst_i.lce_w_v) begin
          mshr_r.lce_id <= mshr_n.lce_id;
        end
        if (decoded_inst_i.addr_w_v) begin
          mshr_r.paddr <= mshr_n.paddr;
        end
        if (decoded_inst_i.msg_size_w_v) begin
          mshr_r.msg_size <= mshr_n.msg_size;
        end
        for (int i = 0; i < num_flags_lp; i++) begin
          if (decoded_inst_i.flag_w_v[i]) begin
            mshr_r.flags[i] <= mshr_n.flags[i];
          end
        end
      end
    end
  end

  assign gpr_o       = gpr_r;
  assign mshr_o      = mshr_r;
  assign coh_state_o = coh_state_r;

  // Requesters send cached reads and writes only to cacheable memory
  pma_cached_req_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (decoded_inst_i.poph && !stall_i && req_cached_type) |-> req_cacheable
  ) else $error("cce_reg: cached request to uncacheable address");

endmodule

/* hdl/cce_top.sv */
// CCE register subsystem top level
// Decoder, one-entry LCE request buffer, ALU and register file.
// Instructions arrive on the top ports, request headers by req/ack.

`timescale 1ns/100ps

module cce_top (
  input  logic                                                      clk_i,
  input  logic                                                      reset_i,
  input  cce_pkg::cce_inst_s                                        instr_i,
  input  logic                                                      instr_v_i,
  input  cce_pkg::lce_req_hdr_s                                     lce_req_i,
  input  logic                                                      lce_req_req_i,
  output logic                                                      lce_req_ack_o,
  output logic                                                      stall_o,
  output logic [cce_pkg::num_gpr_lp-1:0][cce_pkg::gpr_width_lp-1:0] gpr_o,
  output cce_pkg::mshr_s                                            mshr_o,
  output cce_pkg::coh_state_e                                       coh_state_o
);

  import cce_pkg::*;

  decoded_inst_s           decoded;
  lce_req_hdr_s            hdr;
  logic                    hdr_v;
  logic                    pop;
  logic [gpr_width_lp-1:0] alu_res;

  cce_inst_decode i_decode (
    .instr_i   (instr_i),
    .instr_v_i (instr_v_i),
    .hdr_v_i   (hdr_v),
    .decoded_o (decoded),
    .stall_o   (stall_o),
    .pop_o     (pop)
  );

  cce_lce_req_buffer i_req_buffer (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .lce_req_i     (lce_req_i),
    .lce_req_req_i (lce_req_req_i),
    .pop_i         (pop),
    .lce_req_ack_o (lce_req_ack_o),
    .hdr_o         (hdr),
    .hdr_v_o       (hdr_v)
  );

  cce_alu i_alu (
    .decoded_i (decoded),
    .gpr_i     (gpr_o),
    .alu_res_o (alu_res)
  );

  cce_reg i_reg (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .decoded_inst_i (decoded),
    .stall_i        (stall_o),
    .alu_res_i      (alu_res),
    .lce_req_hdr_i  (hdr),
    .gpr_o          (gpr_o),
    .mshr_o         (mshr_o),
    .coh_state_o    (coh_state_o)
  );

endmodule

/* verif/cce_tb.sv */
// CCE register subsystem testbench
// Drives LFSR instruction and LCE request stimulus into the top level and
// compares the GPRs, the MSHR and the coherence state with a reference model

`timescale 1ns/100ps

module cce_tb;

  import cce_pkg::*;

  localparam int test_cycles_lp = 5 + 200 * 2 + 30 * 8 + 4 * 14 + 24 + 8 * 6;

  logic clk_i;
  logic reset_i;
  cce_inst_s instr_i;
  logic instr_v_i;
  lce_req_hdr_s lce_req_i;
  logic lce_req_req_i;
  logic lce_req_ack_o;
  logic stall_o;
  logic [num_gpr_lp-1:0][gpr_width_lp-1:0] gpr_o;
  mshr_s mshr_o;
  coh_state_e coh_state_o;

  // Reference model state
  logic [num_gpr_lp-1:0][gpr_width_lp-1:0] m_gpr;
  mshr_s m_mshr;
  coh_state_e m_coh;
  lce_req_hdr_s m_slot;
  logic m_slot_v;

  logic [15:0] lfsr_q;
  string cur_test;
  int test_errs;
  int fail_tests;
  int num_tests;
  int num_checks;
  int stall_count;

  cce_top i_dut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_i       (instr_i),
    .instr_v_i     (instr_v_i),
    .lce_req_i     (lce_req_i),
    .lce_req_req_i (lce_req_req_i),
    .lce_req_ack_o (lce_req_ack_o),
    .stall_o       (stall_o),
    .gpr_o         (gpr_o),
    .mshr_o        (mshr_o),
    .coh_state_o   (coh_state_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    #(20 * test_cycles_lp * 10);
    $display("Watchdog expired, a handshake or stall never completed");
    $display("TESTS FAILED");
    $finish;
  end

  // Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[14:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return val;
  endfunction

  // Cached reads and writes stay below the uncached base
  function automatic lce_req_hdr_s rand_hdr();
    lce_req_hdr_s h;
    h.msg_type = lce_req_type_e'(2'(take_bits(2)));
    h.src_id   = 2'(take_bits(2));
    if (h.msg_type == e_req_rd || h.msg_type == e_req_wr) begin
      h.paddr = {1'b0, 11'(take_bits(11))};
    end else begin
      h.paddr = 12'(take_bits(12));
    end
    h.size     = 2'(take_bits(2));
    h.non_excl = 1'(take_bits(1));
    return h;
  endfunction

  function automatic cce_inst_s make_inst(input cce_opcode_e op);
    cce_inst_s inst;
    inst.op    = op;
    inst.dst   = 2'(take_bits(2));
    inst.src_a = 2'(take_bits(2));
    inst.imm   = 8'(take_bits(8));
    return inst;
  endfunction

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    num_checks++;
    if (exp !== act) begin
      $display("FAIL %s %s expected %0h actual %0h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_state();
    check_val("gpr", 64'(m_gpr), 64'(gpr_o));
    check_val("mshr", 64'(m_mshr), 64'(mshr_o));
    check_val("coh_state", 64'(m_coh), 64'(coh_state_o));
  endtask

  task automatic model_exec(input cce_inst_s inst);
    logic [gpr_width_lp-1:0] a;
    logic [gpr_width_lp-1:0] b;
    a = m_gpr[inst.src_a];
    b = m_gpr[inst.imm[1:0]];
    case (inst.op)
      e_op_movi: m_gpr[inst.dst] = {8'h00, inst.imm};
      e_op_add:  m_gpr[inst.dst] = a + b;
      e_op_sub:  m_gpr[inst.dst] = a - b;
      e_op_mov:  m_gpr[inst.dst] = a;
      e_op_poph: begin
        if (!m_slot_v) begin
          $display("ERROR %s popped a header that was never acknowledged", cur_test);
          test_errs++;
        end
        m_mshr.lce_id             = m_slot.src_id;
        m_mshr.paddr              = m_slot.paddr;
        m_mshr.msg_size           = m_slot.size;
        m_mshr.flags[e_flag_rqf]  = (m_slot.msg_type == e_req_wr)
                                    || (m_slot.msg_type == e_req_uc_wr);
        m_mshr.flags[e_flag_ucf]  = (m_slot.msg_type == e_req_uc_rd)
                                    || (m_slot.msg_type == e_req_uc_wr);
        m_mshr.flags[e_flag_nerf] = m_slot.non_excl;
        m_mshr.flags[e_flag_rcf]  = (m_slot.paddr < 12'h800);
        m_slot_v = 1'b0;
      end
      e_op_clm: begin
        m_mshr = '0;
        m_mshr.next_coh_state = m_coh;
      end
      e_op_ldflags: m_mshr.flags = a[3:0];
      e_op_setcoh:  m_coh = coh_state_e'(a[1:0]);
      default: begin
      end
    endcase
  endtask

  // Holds the instruction while stalled, registers must not move meanwhile
  task automatic issue_instr(input cce_inst_s inst);
    stall_count = 0;
    @(posedge clk_i);
    instr_i   <= inst;
    instr_v_i <= 1'b1;
    @(negedge clk_i);
    while (stall_o) begin
      stall_count++;
      check_state();
      @(negedge clk_i);
    end
    @(posedge clk_i);
    instr_v_i <= 1'b0;
    model_exec(inst);
    @(negedge clk_i);
  endtask

  task automatic wait_ack(input logic level);
    @(negedge clk_i);
    while (lce_req_ack_o !== level) begin
      @(negedge clk_i);
    end
  endtask

  task automatic start_req(input lce_req_hdr_s h);
    @(posedge clk_i);
    lce_req_i     <= h;
    lce_req_req_i <= 1'b1;
    wait_ack(1'b1);
    m_slot   = h;
    m_slot_v = 1'b1;
  endtask

  task automatic end_req();
    @(posedge clk_i);
    lce_req_req_i <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic finish_test();
    num_tests++;
    if (test_errs == 0) begin
      $display("%s: ok", cur_test);
    end else begin
      $display("%s: %0d check(s) failed", cur_test, test_errs);
      fail_tests++;
    end
    test_errs = 0;
  endtask

  initial begin
    lce_req_hdr_s h;
    lce_req_hdr_s h2;
    cce_inst_s inst;
    int delay;
    logic [1:0] sel;

    reset_i = 1'b1;
    instr_i = '0;
    instr_v_i = 1'b0;
    lce_req_i = '0;
    lce_req_req_i = 1'b0;
    lfsr_q = 16'd12757;
    m_gpr = '0;
    m_mshr = '0;
    m_coh = e_coh_i;
    m_slot = '0;
    m_slot_v = 1'b0;
    test_errs = 0;
    fail_tests = 0;
    num_tests = 0;
    num_checks = 0;

    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);

    cur_test = "reset";
    check_state();
    check_val("ack", 64'(0), 64'(lce_req_ack_o));
    check_val("stall", 64'(0), 64'(stall_o));
    finish_test();

    cur_test = "alu_sequence";
    for (int i = 0; i < 200; i++) begin
      sel = 2'(take_bits(2));
      case (sel)
        2'd0: inst = make_inst(e_op_movi);
        2'd1: inst = make_inst(e_op_add);
        2'd2: inst = make_inst(e_op_sub);
        default: inst = make_inst(e_op_mov);
      endcase
      issue_instr(inst);
      check_val("gpr", 64'(m_gpr), 64'(gpr_o));
    end
    finish_test();

    cur_test = "header_pop";
    for (int i = 0; i < 30; i++) begin
      h = rand_hdr();
      start_req(h);
      end_req();
      issue_instr(make_inst(e_op_poph));
      check_state();
    end
    finish_test();

    cur_test = "stall_backpressure";
    for (int i = 0; i < 4; i++) begin
      delay = 1 + int'(take_bits(3));
      h = rand_hdr();
      // Request is captured delay edges after the pop is presented
      fork
        issue_instr(make_inst(e_op_poph));
        begin
          repeat (delay - 1) @(posedge clk_i);
          start_req(h);
          end_req();
        end
      join
      check_val("stall cycles", 64'(delay), 64'(stall_count));
      check_state();
    end
    h = rand_hdr();
    h2 = rand_hdr();
    start_req(h);
    end_req();
    // Second request against a full buffer
    @(posedge clk_i);
    lce_req_i     <= h2;
    lce_req_req_i <= 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      if (lce_req_ack_o) begin
        $display("ERROR %s acknowledged a request while the buffer was full", cur_test);
        test_errs++;
      end
    end
    issue_instr(make_inst(e_op_poph));
    check_state();
    wait_ack(1'b1);
    m_slot   = h2;
    m_slot_v = 1'b1;
    end_req();
    issue_instr(make_inst(e_op_poph));
    check_state();
    finish_test();

    cur_test = "coh_and_flags";
    for (int i = 0; i < 8; i++) begin
      issue_instr(make_inst(e_op_setcoh));
      check_state();
      issue_instr(make_inst(e_op_clm));
      check_state();
      check_val("clm next_coh", 64'(m_coh), 64'(mshr_o.next_coh_state));
      check_val("clm fields", 64'(0),
                64'({mshr_o.lce_id, mshr_o.paddr, mshr_o.msg_size, mshr_o.flags}));
      issue_instr(make_inst(e_op_ldflags));
      check_state();
    end
    finish_test();

    $display("%0d tests run, %0d failed, %0d checks", num_tests, fail_tests, num_checks);
    if (fail_tests == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* cce_lite.f */
hdl/cce_pkg.sv
hdl/cce_inst_decode.sv
hdl/cce_lce_req_buffer.sv
hdl/cce_alu.sv
hdl/cce_reg.sv
hdl/cce_top.sv
verif/cce_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the CCE register subsystem testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module cce_tb -f cce_lite.f -o cce_sim
./obj_dir/cce_sim 2>&1 | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
  echo "Simulation run succeeded"
  exit 0
else
  echo "Simulation run failed"
  exit 1
fi
